// ==== pixel_output.sv ====
// Pixel output stage
// Final register for sync, display enable and colour
// Colour is widened by repeating each input nibble, forced to white on the
// border and blanked outside the active area

`timescale 1ns/10ps
`include "video_macros.svh"

module pixel_output
(
  input  logic                     clk,
  input  logic                     reset_n,
  input  video_pkg::timing_flags_t flags,
  input  video_pkg::rgb_in_t       rgb_in,
  output logic                     hsync_n,
  output logic                     vsync_n,
  output logic                     de,
  output video_pkg::rgb_out_t      rgb
);

  // How many copies of a nibble fill one output channel
  localparam int REPEAT = `COLOR_OUT_W / `COLOR_IN_W;

  // ============================
  // Colour widening
  // ============================
  // Repeating the nibble maps 0 to 0 and full scale to full scale, with
  // even steps in between
  function automatic logic [`COLOR_OUT_W-1:0] widen(input logic [`COLOR_IN_W-1:0] c);
    return {REPEAT{c}};
  endfunction

  video_pkg::rgb_out_t rgb_d;

  // Border wins over picture data, and anything outside the window is black
  always_comb
  begin
    if (flags.border)
    begin
      rgb_d = '1;
    end
    else if (flags.active)
    begin
      rgb_d.r = widen(rgb_in.r);
      rgb_d.g = widen(rgb_in.g);
      rgb_d.b = widen(rgb_in.b);
    end
    else
    begin
      rgb_d = '0;
    end
  end

  // ============================
  // Output register
  // ============================
  // The colour source is sampled on the same edge that moves the flags out,
  // so no extra colour pipeline is needed
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      hsync_n <= 1'b1;
      vsync_n <= 1'b1;
      de <= 1'b0;
      rgb <= '0;
    end
    else
    begin
      hsync_n <= flags.hsync_n;
      vsync_n <= flags.vsync_n;
      de <= flags.active;
      rgb <= rgb_d;
    end
  end

  // Blanked pixels carry no colour
  a_blank_is_black: assert property (@(posedge clk) disable iff (!reset_n)
    !de |-> (rgb == '0))
    else $error("Non-zero colour while display enable is low");

endmodule

// ==== raster_counter.sv ====
// Raster counter
// Free-running horizontal pixel counter and vertical line counter
// The line counter steps each time the pixel counter wraps, and both wrap
// at the end of the frame

`timescale 1ns/10ps
`include "video_macros.svh"

module raster_counter
(
  input  logic                   clk,
  input  logic                   reset_n,
  output video_pkg::raster_pos_t pos
);

  // ============================
  // Mode totals
  // ============================
  localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;

  // Last position on a line and last line in a frame
  localparam logic [`CNT_W-1:0] H_LAST = `CNT_W'(H_TOTAL - 1);
  localparam logic [`CNT_W-1:0] V_LAST = `CNT_W'(V_TOTAL - 1);

  logic h_last;
  logic v_last;

  assign h_last = (pos.h == H_LAST);
  assign v_last = (pos.v == V_LAST);

  // ============================
  // Counters
  // ============================
  // Reset parks the counters on the final pixel of the frame, so the first
  // edge after release wraps both of them to zero
  // The idle front porch position also decodes to inactive syncs
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      pos.h <= H_LAST;
      pos.v <= V_LAST;
    end
    else
    begin
      if (h_last)
      begin
        pos.h <= '0;
        // Lines only move at the end of a line
        if (v_last)
          pos.v <= '0;
        else
          pos.v <= pos.v + `CNT_W'(1);
      end
      else
      begin
        pos.h <= pos.h + `CNT_W'(1);
      end
    end
  end

  // Neither counter ever runs past its total
  a_pos_in_range: assert property (@(posedge clk) disable iff (!reset_n)
    (pos.h <= H_LAST) && (pos.v <= V_LAST))
    else $error("Raster position out of range h=%0d v=%0d", pos.h, pos.v);

endmodule

// ==== timing_decode.sv ====
// Timing decoder
// Turns the raster position into sync, active and border flags
// All flags are registered, so they describe the position one cycle back

`timescale 1ns/10ps
`include "video_macros.svh"

module timing_decode
(
  input  logic                     clk,
  input  logic                     reset_n,
  input  video_pkg::raster_pos_t   pos,
  output video_pkg::timing_flags_t flags
);

  // ============================
  // Window edges
  // ============================
  // Sync starts at count zero, back porch follows, then the active window
  localparam int H_ACT_START = `H_SYNC + `H_BACK;
  localparam int V_ACT_START = `V_SYNC + `V_BACK;

  // Last count inside each sync pulse
  localparam logic [`CNT_W-1:0] H_SYNC_LAST = `CNT_W'(`H_SYNC - 1);
  localparam logic [`CNT_W-1:0] V_SYNC_LAST = `CNT_W'(`V_SYNC - 1);

  // First and last count inside the active window
  localparam logic [`CNT_W-1:0] H_ACT_FIRST = `CNT_W'(H_ACT_START);
  localparam logic [`CNT_W-1:0] H_ACT_LAST = `CNT_W'(H_ACT_START + `H_ACTIVE - 1);
  localparam logic [`CNT_W-1:0] V_ACT_FIRST = `CNT_W'(V_ACT_START);
  localparam logic [`CNT_W-1:0] V_ACT_LAST = `CNT_W'(V_ACT_START + `V_ACTIVE - 1);

  // ============================
  // Position compares
  // ============================
  logic h_in_sync;
  logic v_in_sync;
  logic h_in_act;
  logic v_in_act;
  logic h_on_edge;
  logic v_on_edge;

  video_pkg::timing_flags_t flags_d;

  assign h_in_sync = (pos.h <= H_SYNC_LAST);
  assign v_in_sync = (pos.v <= V_SYNC_LAST);

  assign h_in_act = (pos.h >= H_ACT_FIRST) && (pos.h <= H_ACT_LAST);
  assign v_in_act = (pos.v >= V_ACT_FIRST) && (pos.v <= V_ACT_LAST);

  // First or last column, first or last row of the picture
  assign h_on_edge = (pos.h == H_ACT_FIRST) || (pos.h == H_ACT_LAST);
  assign v_on_edge = (pos.v == V_ACT_FIRST) || (pos.v == V_ACT_LAST);

  always_comb
  begin
    flags_d.hsync_n = !h_in_sync;
    flags_d.vsync_n = !v_in_sync;
    flags_d.active = h_in_act && v_in_act;
    // A column edge only counts on an active line and a row edge only in an active column
    flags_d.border = (h_on_edge && v_in_act) || (v_on_edge && h_in_act);
  end

  // ============================
  // Flag register
  // ============================
  // Idle values are syncs released and the picture blanked
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      flags.hsync_n <= 1'b1;
      flags.vsync_n <= 1'b1;
      flags.active <= 1'b0;
      flags.border <= 1'b0;
    end
    else
    begin
      flags <= flags_d;
    end
  end

  // A border pixel is always an active pixel
  a_border_in_active: assert property (@(posedge clk) disable iff (!reset_n)
    flags.border |-> flags.active)
    else $error("Border flag set outside the active area");

  // The active window sits clear of both sync pulses
  a_active_clear_of_sync: assert property (@(posedge clk) disable iff (!reset_n)
    flags.active |-> (flags.hsync_n && flags.vsync_n))
    else $error("Active flag set during a sync pulse");

endmodule

// ==== video_macros.svh ====
// Video timing macros
// Mode geometry for the 256x256 raster timing generator, plus the counter
// width and the colour channel widths shared by the package and the RTL
// Another mode is selected by editing the phase lengths below

`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// ============================
// Horizontal phases in pixel clocks
// ============================
// A line is sync, back porch, active, front porch in that order
`define H_ACTIVE 256
`define H_FRONT 8
`define H_SYNC 40
`define H_BACK 16

// ============================
// Vertical phases in lines
// ============================
// A frame follows the same order as a line
`define V_ACTIVE 256
`define V_FRONT 8
`define V_SYNC 7
`define V_BACK 16

// Width of both position counters, wide enough for far larger modes
`define CNT_W 12

// Colour arrives as nibbles and leaves as bytes
// The output width is expected to be a whole multiple of the input width
`define COLOR_IN_W 4
`define COLOR_OUT_W 8

`endif

// ==== video_pkg.sv ====
// Video types
// Packed structures passed between the raster counter, the timing decoder,
// the output stage and the testbench

`include "video_macros.svh"

package video_pkg;

  // ============================
  // Raster position
  // ============================
  // Horizontal count in the upper half, line count in the lower half
  typedef struct packed {
    logic [`CNT_W-1:0] h;
    logic [`CNT_W-1:0] v;
  } raster_pos_t;

  // ============================
  // Decoded timing flags
  // ============================
  // Both syncs are active low
  // Border marks the outermost ring of the active area and is only ever
  // set together with active
  typedef struct packed {
    logic hsync_n;
    logic vsync_n;
    logic active;
    logic border;
  } timing_flags_t;

  // ============================
  // Colour words
  // ============================
  // Input colour, one nibble per channel
  typedef struct packed {
    logic [`COLOR_IN_W-1:0] r;
    logic [`COLOR_IN_W-1:0] g;
    logic [`COLOR_IN_W-1:0] b;
  } rgb_in_t;

  // Output colour, one byte per channel
  typedef struct packed {
    logic [`COLOR_OUT_W-1:0] r;
    logic [`COLOR_OUT_W-1:0] g;
    logic [`COLOR_OUT_W-1:0] b;
  } rgb_out_t;

endpackage

// ==== video_top.f ====
+incdir+.
video_pkg.sv
raster_counter.sv
timing_decode.sv
pixel_output.sv
video_top.sv
video_top_tb.sv

// ==== video_top.sv ====
// Video timing top level
// Raster counter, timing decoder and output stage in one two-stage pipeline
// Every output reflects the raster position from two clock edges earlier

`timescale 1ns/10ps

module video_top
(
  input  logic                clk,
  input  logic                reset_n,
  input  video_pkg::rgb_in_t  rgb_in,
  output logic                hsync_n,
  output logic                vsync_n,
  output logic                de,
  output video_pkg::rgb_out_t rgb
);

  // ============================
  // Internal pipeline signals
  // ============================
  // Counter position, zero latency from the counter registers
  video_pkg::raster_pos_t pos;

  // Decoded flags, one cycle behind the position
  video_pkg::timing_flags_t flags;

  // ============================
  // Stage 0, raster counting
  // ============================
  raster_counter u_raster_counter
  (
    .clk     (clk),
    .reset_n (reset_n),
    .pos     (pos)
  );

  // ============================
  // Stage 1, position decode
  // ============================
  timing_decode u_timing_decode
  (
    .clk     (clk),
    .reset_n (reset_n),
    .pos     (pos),
    .flags   (flags)
  );

  // ============================
  // Stage 2, output register
  // ============================
  // Colour enters here directly and is sampled every clock
  pixel_output u_pixel_output
  (
    .clk     (clk),
    .reset_n (reset_n),
    .flags   (flags),
    .rgb_in  (rgb_in),
    .hsync_n (hsync_n),
    .vsync_n (vsync_n),
    .de      (de),
    .rgb     (rgb)
  );

endmodule

// ==== video_top_tb.sv ====
// Video timing testbench
// Runs the raster generator through reset and two full frames with random
// colour from an LFSR, and compares every output after every clock edge with
// a reference model of the line and frame layout
// Also counts sync and display enable cycles per line and per frame

`timescale 1ns/10ps
`include "video_macros.svh"

module video_top_tb;

  // ============================
  // Mode geometry
  // ============================
  localparam int H_TOTAL = `H_SYNC + `H_BACK + `H_ACTIVE + `H_FRONT;
  localparam int V_TOTAL = `V_SYNC + `V_BACK + `V_ACTIVE + `V_FRONT;
  localparam int H_ACT_FIRST = `H_SYNC + `H_BACK;
  localparam int H_ACT_LAST = H_ACT_FIRST + `H_ACTIVE - 1;
  localparam int V_ACT_FIRST = `V_SYNC + `V_BACK;
  localparam int V_ACT_LAST = V_ACT_FIRST + `V_ACTIVE - 1;
  localparam int REPEAT = `COLOR_OUT_W / `COLOR_IN_W;

  // Run length is two frames plus the two idle edges of the pipeline
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int PIPE_DEPTH = 2;
  localparam int RESET_CYCLES = 4;
  localparam int RUN_CYCLES = 2 * FRAME_CYCLES + PIPE_DEPTH;
  // About 16,000 cycles of margin over reset plus the run
  localparam int TIMEOUT_CYCLES = 200000;

  localparam logic [31:0] LFSR_SEED = 32'hf27158d6;
  localparam logic [31:0] LFSR_TAPS = 32'h80200003;

  // ============================
  // DUT signals
  // ============================
  logic                clk;
  logic                reset_n;
  video_pkg::rgb_in_t  rgb_in;
  logic                hsync_n;
  logic                vsync_n;
  logic                de;
  video_pkg::rgb_out_t rgb;

  // Random source and bookkeeping
  logic [31:0] lfsr_state;
  int          error_count = 0;
  int          cycle_count = 0;
  int          edge_count;

  // Model position now and one edge back
  int cur_h;
  int cur_v;
  int old_h;
  int old_v;

  // Observed counts per line and per frame
  int   hs_low_line;
  int   de_line;
  int   vs_low_frame;
  int   de_frame;
  int   frames_done;
  logic last_vsync;

  video_top DUT
  (
    .clk     (clk),
    .reset_n (reset_n),
    .rgb_in  (rgb_in),
    .hsync_n (hsync_n),
    .vsync_n (vsync_n),
    .de      (de),
    .rgb     (rgb)
  );

  // 100 ns clock period
  always #50 clk = ~clk;

  // Hard stop in case the run never reaches its end
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d clock cycles, the test never reached its end", cycle_count);
      $display("ERRORS FOUND");
      $fatal(1, "Simulation stopped by the cycle limit");
    end
  end

  // ============================
  // Helpers
  // ============================
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      error_count = error_count + 1;
      $display("FAIL at %0d ns: %s is %0h, expected %0h", $time, what, got, expected);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // One step of a 32-bit Galois LFSR, bit 0 is the bit taken
  function automatic logic [31:0] next_lfsr(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ LFSR_TAPS;
    else
      return state >> 1;
  endfunction

  // Build a colour word one LFSR bit at a time
  task automatic draw_colour(output video_pkg::rgb_in_t c);
    logic [$bits(video_pkg::rgb_in_t)-1:0] bits;
    int i;
    bits = '0;
    for (i = 0; i < $bits(video_pkg::rgb_in_t); i++)
    begin
      bits = {bits[$bits(video_pkg::rgb_in_t)-2:0], lfsr_state[0]};
      lfsr_state = next_lfsr(lfsr_state);
    end
    c = bits;
  endtask

  // Outputs that a position and an input colour should produce
  task automatic expected_outputs(input int h, input int v, input video_pkg::rgb_in_t c,
                                  output logic hs, output logic vs, output logic en,
                                  output video_pkg::rgb_out_t px);
    logic h_act;
    logic v_act;
    logic ring;
    h_act = (h >= H_ACT_FIRST) && (h <= H_ACT_LAST);
    v_act = (v >= V_ACT_FIRST) && (v <= V_ACT_LAST);
    ring = (h == H_ACT_FIRST) || (h == H_ACT_LAST) || (v == V_ACT_FIRST) || (v == V_ACT_LAST);
    hs = !(h < `H_SYNC);
    vs = !(v < `V_SYNC);
    en = h_act && v_act;
    if (en && ring)
    begin
      px = '1;
    end
    else if (en)
    begin
      px.r = {REPEAT{c.r}};
      px.g = {REPEAT{c.g}};
      px.b = {REPEAT{c.b}};
    end
    else
    begin
      px = '0;
    end
  endtask

  // Syncs released, picture blanked
  task automatic check_idle(input string when);
    check_value({"hsync_n ", when}, hsync_n, 1'b1);
    check_value({"vsync_n ", when}, vsync_n, 1'b1);
    check_value({"de ", when}, de, 1'b0);
    check_value({"rgb ", when}, rgb, '0);
  endtask

  // Model counters wrap exactly like the raster, old_* trails by one edge
  task automatic step_model();
    old_h = cur_h;
    old_v = cur_v;
    if (cur_h == H_TOTAL - 1)
    begin
      cur_h = 0;
      cur_v = (cur_v == V_TOTAL - 1) ? 0 : cur_v + 1;
    end
    else
    begin
      cur_h = cur_h + 1;
    end
  endtask

  // ============================
  // Per-edge check
  // ============================
  // Outputs after an edge describe the position two edges back, and the colour
  // is the one held at that same edge
  task automatic check_edge();
    logic exp_hs;
    logic exp_vs;
    logic exp_de;
    video_pkg::rgb_out_t exp_rgb;
    logic line_active;
    expected_outputs(old_h, old_v, rgb_in, exp_hs, exp_vs, exp_de, exp_rgb);
    check_value("hsync_n", hsync_n, exp_hs);
    check_value("vsync_n", vsync_n, exp_vs);
    check_value("de", de, exp_de);
    check_value("rgb", rgb, exp_rgb);
    if (!de)
      check_value("rgb while de is low", rgb, '0);
    if (edge_count <= PIPE_DEPTH)
      check_idle("just after reset release");
    if (edge_count > PIPE_DEPTH)
    begin
      if (!hsync_n)
        hs_low_line = hs_low_line + 1;
      if (!vsync_n)
        vs_low_frame = vs_low_frame + 1;
      if (de)
      begin
        de_line = de_line + 1;
        de_frame = de_frame + 1;
      end
      // vsync may only move on the first pixel of a line
      if (vsync_n !== last_vsync)
        check_value("line position at a vsync change", old_h, 0);
      if (old_h == H_TOTAL - 1)
      begin
        line_active = (old_v >= V_ACT_FIRST) && (old_v <= V_ACT_LAST);
        check_value("hsync_n low cycles in a line", hs_low_line, `H_SYNC);
        check_value("de high cycles in a line", de_line, line_active ? `H_ACTIVE : 0);
        hs_low_line = 0;
        de_line = 0;
        if (old_v == V_TOTAL - 1)
        begin
          check_value("vsync_n low cycles in a frame", vs_low_frame, `V_SYNC * H_TOTAL);
          check_value("de high cycles in a frame", de_frame, `H_ACTIVE * `V_ACTIVE);
          vs_low_frame = 0;
          de_frame = 0;
          frames_done = frames_done + 1;
        end
      end
    end
    last_vsync = vsync_n;
  endtask

  // ============================
  // Main sequence
  // ============================
  initial
  begin
    clk = 1'b0;
    reset_n = 1'b0;
    rgb_in = '0;
    lfsr_state = LFSR_SEED;
    // Same parking position as the raster counter in reset
    cur_h = H_TOTAL - 1;
    cur_v = V_TOTAL - 1;
    old_h = cur_h;
    old_v = cur_v;
    hs_low_line = 0;
    de_line = 0;
    vs_low_frame = 0;
    de_frame = 0;
    frames_done = 0;
    last_vsync = 1'b1;

    // Outputs stay idle throughout reset, colour already toggles
    repeat (RESET_CYCLES)
    begin
      @(negedge clk);
      check_idle("during reset");
      draw_colour(rgb_in);
    end
    reset_n = 1'b1;

    // Sample on the falling edge where outputs are stable, then drive
    for (edge_count = 1; edge_count <= RUN_CYCLES; edge_count++)
    begin
      @(negedge clk);
      check_edge();
      step_model();
      draw_colour(rgb_in);
    end

    check_value("completed frames", frames_done, 2);
    if (error_count == 0)
    begin
      $display("NO ERRORS");
      $finish;
    end
    else
    begin
      $display("ERRORS FOUND");
      $fatal(1, "Run ended with mismatches");
    end
  end

endmodule
